//--- flist.f
source/cpu_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/register_access.sv
source/execute_unit.sv
source/writeback_unit.sv
source/cpu_top.sv
verification/cpu_props.sv
verification/cpu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f flist.f -o cpu_tb_sim

if ./obj_dir/cpu_tb_sim | tee /dev/stderr | grep -x "test passed" > /dev/null; then
   exit 0
fi
echo "Simulation did not report a pass" >&2
exit 1

//--- verification/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

   localparam int    NUM_PROGS       = 4;
   localparam int    MAX_INSTR       = 12;
   localparam int    RESET_CYCLES    = 10;
   localparam int    DRAIN_CYCLES    = 20;
   localparam int    HALT_LIMIT      = MAX_INSTR * 40;
   localparam int    WATCHDOG_CYCLES = NUM_PROGS * (HALT_LIMIT + RESET_CYCLES + DRAIN_CYCLES);
   localparam addr_t PROG_BASE       = 32'h0000_1000;
   localparam int    NONE = 0, RANDOM = 1, HEAVY = 2;  // Stall modes

   logic  clk, rst_n;
   logic  imem_valid, imem_ready, imem_dp_valid, imem_dp_ready;
   addr_t imem_address;
   word_t imem_dp_read_data;
   logic  wmem_valid, wmem_ready;
   addr_t wmem_address;
   word_t wmem_wr_data;
   logic  halted;

   // Program table with stall mode and hand-counted stores
   word_t prog_words [NUM_PROGS][MAX_INSTR];
   int    prog_len [NUM_PROGS];
   int    prog_mode [NUM_PROGS];
   int    prog_stores [NUM_PROGS];

   addr_t       exp_addr [$];
   word_t       exp_data [$];
   int          cur_prog;
   int          errors;
   int          stores_seen;
   int          total_stores;
   logic [31:0] lcg_state = 32'h5168_45e8;

   cpu_top #(.RESET_PC(PROG_BASE)) i_cpu_top (.*);

   bind cpu_top cpu_props i_cpu_props (
      .clk, .rst_n, .imem_valid, .imem_ready, .imem_address,
      .wmem_valid, .wmem_ready, .wmem_address, .wmem_wr_data, .halted
   );

   // Opcode 31:28, dst 27:25, src 24:22, imm 15:0
   function automatic word_t encode(opcode_e op, reg_idx_t dst, reg_idx_t src, logic [15:0] imm);
      return {op, dst, src, 6'b0, imm};
   endfunction

   task automatic add_instr(int p, word_t w);
      prog_words[p][prog_len[p]] = w;
      prog_len[p]++;
   endtask

   task automatic load_programs();
      foreach (prog_len[p]) prog_len[p] = 0;
      add_instr(0, encode(op_movi, 1, 0, 16'hffff));  // ALU results
      add_instr(0, encode(op_movi, 2, 0, 16'h1234));
      add_instr(0, encode(op_add, 1, 2, 0));
      add_instr(0, encode(op_store, 1, 0, 16'h0010));
      add_instr(0, encode(op_sub, 2, 1, 0));           // Wraps below zero
      add_instr(0, encode(op_store, 2, 0, 16'h0014));
      add_instr(0, encode(op_movi, 3, 0, 16'h0ff0));
      add_instr(0, encode(op_and, 3, 2, 0));
      add_instr(0, encode(op_store, 3, 0, 16'h0018));
      add_instr(0, encode(op_or, 3, 1, 0));
      add_instr(0, encode(op_xor, 3, 2, 0));
      add_instr(0, encode(op_store, 3, 0, 16'h001c)); // Halt comes from past the end
      add_instr(1, encode(op_store, 5, 0, 16'h0040)); // Never written, reads zero
      add_instr(1, encode(op_movi, 4, 0, 16'h0007));
      add_instr(1, encode(op_store, 4, 0, 16'h0044));
      add_instr(1, encode(op_add, 4, 4, 0));
      add_instr(1, encode(op_add, 4, 4, 0));
      add_instr(1, encode(op_store, 4, 0, 16'h0048));
      add_instr(1, encode(op_movi, 5, 0, 16'h00aa));
      add_instr(1, encode(op_xor, 5, 4, 0));
      add_instr(1, encode(op_store, 5, 0, 16'h004c));
      add_instr(1, encode(op_halt, 0, 0, 0));
      add_instr(2, encode(op_movi, 0, 0, 16'h0001));  // Store heavy
      add_instr(2, encode(op_store, 0, 0, 16'h0080));
      add_instr(2, encode(op_add, 0, 0, 0));
      add_instr(2, encode(op_store, 0, 0, 16'h0084));
      add_instr(2, encode(op_movi, 7, 0, 16'hbeef));
      add_instr(2, encode(op_store, 7, 0, 16'h0088));
      add_instr(2, encode(op_sub, 7, 0, 0));
      add_instr(2, encode(op_store, 7, 0, 16'h008c));
      add_instr(2, encode(op_store, 0, 0, 16'h0090));
      add_instr(2, encode(op_halt, 0, 0, 0));
      add_instr(3, encode(op_movi, 6, 0, 16'h0055));
      add_instr(3, encode(op_store, 6, 0, 16'h00c0));
      add_instr(3, encode(op_halt, 0, 0, 0));
      add_instr(3, encode(op_store, 6, 0, 16'h00c4)); // Must never appear
      add_instr(3, encode(op_movi, 6, 0, 16'h0001));
      add_instr(3, encode(op_store, 6, 0, 16'h00c8));
      prog_mode   = '{NONE, RANDOM, HEAVY, RANDOM};
      prog_stores = '{4, 4, 5, 1};
   endtask

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic ready_draw(int mode);
      logic [31:0] r;
      r = lcg_next();
      if (mode == NONE) return 1'b1;
      if (mode == RANDOM) return r[31];
      return r[31:30] == 2'b00;  // Heavy, one in four
   endfunction

   function automatic int data_delay(int mode);
      logic [31:0] r;
      r = lcg_next();
      if (mode == NONE) return 0;
      if (mode == RANDOM) return int'(r[31:30]);
      return int'(r[31:29]);
   endfunction

   function automatic word_t fetch_word(addr_t addr);
      addr_t offset;
      offset = addr - PROG_BASE;
      if (offset[1:0] == 2'b00 && offset < addr_t'(4 * prog_len[cur_prog]))
         return prog_words[cur_prog][int'(offset >> 2)];
      return encode(op_halt, 0, 0, 0);
   endfunction

   task automatic check(string name, logic [31:0] got, logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_store(addr_t addr, word_t data);
      if (halted) begin
         errors++;
         $display("Store to 0x%h went out after halted rose", addr);
      end
      if (exp_addr.size() == 0) begin
         errors++;
         $display("Extra store to 0x%h with data 0x%h", addr, data);
      end else begin
         check("wmem_address", addr, exp_addr.pop_front());
         check("wmem_wr_data", data, exp_data.pop_front());
      end
      stores_seen++;
   endtask

   // Executes the program in order and queues the stores it must make
   task automatic build_expected(int p);
      word_t    regs [NUM_REGS];
      word_t    w;
      reg_idx_t d, s;
      logic     done;
      exp_addr.delete();
      exp_data.delete();
      done = 1'b0;
      foreach (regs[r]) regs[r] = '0;
      for (int i = 0; i < prog_len[p] && !done; i++) begin
         w = prog_words[p][i];
         d = w[27:25];
         s = w[24:22];
         case (w[31:28])
            op_movi:  regs[d] = {16'h0, w[15:0]};
            op_add:   regs[d] = regs[d] + regs[s];
            op_sub:   regs[d] = regs[d] - regs[s];
            op_and:   regs[d] = regs[d] & regs[s];
            op_or:    regs[d] = regs[d] | regs[s];
            op_xor:   regs[d] = regs[d] ^ regs[s];
            op_store: begin
               exp_addr.push_back({16'h0, w[15:0]});
               exp_data.push_back(regs[d]);
            end
            default:  done = 1'b1;  // Halt and unknown codes
         endcase
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
      $display("test failed");
      $finish;
   end

   // Instruction memory and store port, sampled at the falling edge
   initial begin : bus_models
      logic  imem_take, dp_take, in_reset, pending;
      addr_t take_addr, pend_addr;
      int    delay;
      imem_ready        = 1'b0;
      imem_dp_valid     = 1'b0;
      imem_dp_read_data = '0;
      wmem_ready        = 1'b0;
      pending           = 1'b0;
      pend_addr         = '0;
      delay             = 0;
      forever begin
         @(negedge clk);
         in_reset  = !rst_n;
         imem_take = imem_valid && imem_ready;
         take_addr = imem_address;
         dp_take   = imem_dp_valid && imem_dp_ready;
         if (wmem_valid && wmem_ready) check_store(wmem_address, wmem_wr_data);
         @(posedge clk);
         #5;
         if (in_reset) begin
            imem_ready    = 1'b0;
            imem_dp_valid = 1'b0;
            wmem_ready    = 1'b0;
            pending       = 1'b0;
         end else begin
            if (dp_take) begin
               imem_dp_valid = 1'b0;
               pending       = 1'b0;
            end
            if (imem_take) begin
               if (pending) begin
                  errors++;
                  $display("Second instruction request taken while one was outstanding");
               end
               pending   = 1'b1;
               pend_addr = take_addr;
               delay     = data_delay(prog_mode[cur_prog]);
            end
            if (pending && !imem_dp_valid) begin
               if (delay == 0) begin
                  imem_dp_valid     = 1'b1;
                  imem_dp_read_data = fetch_word(pend_addr);
               end else begin
                  delay--;
               end
            end
            imem_ready = ready_draw(prog_mode[cur_prog]);
            wmem_ready = ready_draw(prog_mode[cur_prog]);
         end
      end
   end

   initial begin : main
      int cycles;
      rst_n        = 1'b0;
      cur_prog     = 0;
      errors       = 0;
      total_stores = 0;
      load_programs();
      for (int p = 0; p < NUM_PROGS; p++) begin
         rst_n = 1'b0;
         @(posedge clk);
         #5;
         cur_prog    = p;  // DUT is in reset here, no port activity
         stores_seen = 0;
         build_expected(p);
         repeat (RESET_CYCLES - 1) begin
            @(posedge clk);
            #5;
         end
         check("halted", halted, 0);
         check("imem_valid", imem_valid, 0);
         check("imem_dp_ready", imem_dp_ready, 0);
         check("wmem_valid", wmem_valid, 0);
         rst_n  = 1'b1;
         cycles = 0;
         while (!halted && cycles < HALT_LIMIT) begin
            @(posedge clk);
            #5;
            cycles++;
         end
         if (!halted) begin
            errors++;
            $display("Program %0d did not raise halted within %0d cycles", p, HALT_LIMIT);
         end
         repeat (DRAIN_CYCLES) begin
            @(posedge clk);
            #5;
         end
         if (exp_addr.size() != 0) begin
            errors++;
            $display("Program %0d: %0d expected stores never appeared", p, exp_addr.size());
         end
         check("store count", stores_seen, prog_stores[p]);
         total_stores += stores_seen;
      end
      $display("Done: %0d errors, %0d stores over %0d programs", errors, total_stores, NUM_PROGS);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

//--- verification/cpu_props.sv
`timescale 1ns/1ps

module cpu_props import cpu_pkg::*; (
   input logic  clk,
   input logic  rst_n,
   input logic  imem_valid,
   input logic  imem_ready,
   input addr_t imem_address,
   input logic  wmem_valid,
   input logic  wmem_ready,
   input addr_t wmem_address,
   input word_t wmem_wr_data,
   input logic  halted
);

   // Stalled store keeps address and data
   assert property (@(posedge clk) disable iff (!rst_n)
      (wmem_valid && !wmem_ready) |=>
         (wmem_valid && $stable(wmem_address) && $stable(wmem_wr_data)))
      else $error("wmem address or data changed while the store was stalled");

   assert property (@(posedge clk) disable iff (!rst_n)
      (imem_valid && !imem_ready) |=> (imem_valid && $stable(imem_address)))
      else $error("imem request dropped or moved before it was taken");

   // Sticky until reset
   assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
      else $error("halted fell without a reset");

endmodule

//--- source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
   parameter addr_t RESET_PC = '0
) (
   input  logic  clk,
   input  logic  rst_n,

   output logic  imem_valid,
   input  logic  imem_ready,
   output addr_t imem_address,
   input  logic  imem_dp_valid,
   output logic  imem_dp_ready,
   input  word_t imem_dp_read_data,

   output logic  wmem_valid,
   input  logic  wmem_ready,
   output addr_t wmem_address,
   output word_t wmem_wr_data,

   output logic  halted
);

   logic      f_valid, f_ready;
   word_t     f_instr;
   logic      d_valid, d_ready;
   decoded_t  d_instr;
   logic      r_valid, r_ready;
   operands_t r_ops;
   logic      e_valid, e_ready;
   result_t   e_res;

   logic      e_pending_valid, w_pending_valid;
   reg_idx_t  e_pending_dst, w_pending_dst;

   // Register write from writeback
   logic      wb_en;
   reg_idx_t  wb_dst;
   word_t     wb_data;

   fetch_unit #(.RESET_PC(RESET_PC)) i_fetch_unit (
      .clk, .rst_n,
      .imem_valid, .imem_ready, .imem_address,
      .imem_dp_valid, .imem_dp_ready, .imem_dp_read_data,
      .f_valid, .f_ready, .f_instr
   );

   decode_unit i_decode_unit (
      .clk, .rst_n,
      .f_valid, .f_ready, .f_instr,
      .d_valid, .d_ready, .d_instr
   );

   register_access i_register_access (
      .clk, .rst_n,
      .d_valid, .d_ready, .d_instr,
      .r_valid, .r_ready, .r_ops,
      .e_pending_valid, .e_pending_dst,
      .w_pending_valid, .w_pending_dst,
      .wb_en, .wb_dst, .wb_data
   );

   execute_unit i_execute_unit (
      .clk, .rst_n,
      .r_valid, .r_ready, .r_ops,
      .e_valid, .e_ready, .e_res,
      .e_pending_valid, .e_pending_dst
   );

   writeback_unit i_writeback_unit (
      .clk, .rst_n,
      .e_valid, .e_ready, .e_res,
      .wb_en, .wb_dst, .wb_data,
      .w_pending_valid, .w_pending_dst,
      .wmem_valid, .wmem_ready, .wmem_address, .wmem_wr_data,
      .halted
   );

endmodule

//--- source/writeback_unit.sv
`timescale 1ns/1ps

module writeback_unit import cpu_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,

   input  logic     e_valid,
   output logic     e_ready,
   input  result_t  e_res,

   output logic     wb_en,
   output reg_idx_t wb_dst,
   output word_t    wb_data,
   output logic     w_pending_valid,
   output reg_idx_t w_pending_dst,

   output logic     wmem_valid,
   input  logic     wmem_ready,
   output addr_t    wmem_address,
   output word_t    wmem_wr_data,

   output logic     halted
);

   logic is_store;

   assign is_store = (e_res.opcode == op_store);

   // After halt everything is drained and dropped
   assign e_ready = halted || !is_store || wmem_ready;

   assign wb_en   = e_valid && !halted && writes_reg(e_res.opcode);
   assign wb_dst  = e_res.dst;
   assign wb_data = e_res.value;

   assign w_pending_valid = wb_en;
   assign w_pending_dst   = e_res.dst;

   assign wmem_valid   = e_valid && is_store && !halted;
   assign wmem_address = e_res.address;  // Held by execute until taken
   assign wmem_wr_data = e_res.value;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         halted <= 1'b0;
      end else if (e_valid && (e_res.opcode == op_halt)) begin
         halted <= 1'b1;  // Sticky until reset
      end
   end

endmodule

//--- source/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import cpu_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,

   input  logic      r_valid,
   output logic      r_ready,
   input  operands_t r_ops,

   output logic      e_valid,
   input  logic      e_ready,
   output result_t   e_res,

   output logic      e_pending_valid,
   output reg_idx_t  e_pending_dst
);

   word_t alu_out;

   always_comb begin
      case (r_ops.opcode)
         op_movi:  alu_out = r_ops.imm;
         op_add:   alu_out = r_ops.a + r_ops.b;  // Wraps at 32 bits
         op_sub:   alu_out = r_ops.a - r_ops.b;
         op_and:   alu_out = r_ops.a & r_ops.b;
         op_or:    alu_out = r_ops.a | r_ops.b;
         op_xor:   alu_out = r_ops.a ^ r_ops.b;
         op_store: alu_out = r_ops.a;            // Store data
         default:  alu_out = '0;
      endcase
   end

   assign r_ready = !e_valid || e_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         e_valid <= 1'b0;
      end else if (r_valid && r_ready) begin
         e_valid <= 1'b1;
      end else if (e_ready) begin
         e_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (r_valid && r_ready) begin
         e_res <= '{
            opcode:  r_ops.opcode,
            dst:     r_ops.dst,
            value:   alu_out,
            address: addr_t'(r_ops.imm)
         };
      end
   end

   assign e_pending_valid = e_valid && writes_reg(e_res.opcode);
   assign e_pending_dst   = e_res.dst;

endmodule

//--- source/register_access.sv
`timescale 1ns/1ps

module register_access import cpu_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,

   input  logic      d_valid,
   output logic      d_ready,
   input  decoded_t  d_instr,

   output logic      r_valid,
   input  logic      r_ready,
   output operands_t r_ops,

   input  logic      e_pending_valid,
   input  reg_idx_t  e_pending_dst,
   input  logic      w_pending_valid,
   input  reg_idx_t  w_pending_dst,

   input  logic      wb_en,
   input  reg_idx_t  wb_dst,
   input  word_t     wb_data
);

   word_t regs [NUM_REGS];
   word_t dst_val;
   word_t src_val;
   logic  r_busy;
   logic  hazard;

   // Store reads dst, so both fields count
   function automatic logic hits(logic busy, reg_idx_t busy_dst, decoded_t instr);
      return busy && ((busy_dst == instr.src) || (busy_dst == instr.dst));
   endfunction

   assign r_busy = r_valid && writes_reg(r_ops.opcode);  // Own output not yet in execute

   assign hazard = hits(r_busy, r_ops.dst, d_instr)
                || hits(e_pending_valid, e_pending_dst, d_instr)
                || hits(w_pending_valid, w_pending_dst, d_instr);

   assign d_ready = (!r_valid || r_ready) && !hazard;

   // Write-through from writeback in the same cycle
   assign dst_val = (wb_en && (wb_dst == d_instr.dst)) ? wb_data : regs[d_instr.dst];
   assign src_val = (wb_en && (wb_dst == d_instr.src)) ? wb_data : regs[d_instr.src];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_en) begin
         regs[wb_dst] <= wb_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         r_valid <= 1'b0;
      end else if (d_valid && d_ready) begin
         r_valid <= 1'b1;
      end else if (r_ready) begin
         r_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (d_valid && d_ready) begin
         r_ops <= '{
            opcode: d_instr.opcode,
            dst:    d_instr.dst,
            a:      dst_val,
            b:      src_val,
            imm:    d_instr.imm
         };
      end
   end

endmodule

//--- source/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import cpu_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,

   input  logic     f_valid,
   output logic     f_ready,
   input  word_t    f_instr,

   output logic     d_valid,
   input  logic     d_ready,
   output decoded_t d_instr
);

   logic [3:0] opc_field;
   decoded_t   fields;

   assign opc_field = f_instr[OPC_LSB +: 4];

   always_comb begin
      // Unknown opcodes stop the machine
      if (opc_field > 4'(op_halt)) begin
         fields.opcode = op_halt;
      end else begin
         fields.opcode = opcode_e'(opc_field);
      end
      fields.dst = f_instr[DST_LSB +: 3];
      fields.src = f_instr[SRC_LSB +: 3];
      fields.imm = {{($bits(word_t) - IMM_W){1'b0}}, f_instr[IMM_W-1:0]};
   end

   // Take a new word whenever the stage register empties this cycle
   assign f_ready = !d_valid || d_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         d_valid <= 1'b0;
      end else if (f_valid && f_ready) begin
         d_valid <= 1'b1;
      end else if (d_ready) begin
         d_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (f_valid && f_ready) begin
         d_instr <= fields;
      end
   end

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; #(
   parameter addr_t RESET_PC = '0
) (
   input  logic  clk,
   input  logic  rst_n,

   output logic  imem_valid,
   input  logic  imem_ready,
   output addr_t imem_address,
   input  logic  imem_dp_valid,
   output logic  imem_dp_ready,
   input  word_t imem_dp_read_data,

   output logic  f_valid,
   input  logic  f_ready,
   output word_t f_instr
);

   typedef enum logic [1:0] {
      fetch_request,
      fetch_wait,
      fetch_hold
   } fetch_state_e;

   fetch_state_e state;
   addr_t        pc;
   word_t        slot;

   assign imem_address  = pc;
   assign imem_dp_ready = (state == fetch_wait);  // Slot is empty while waiting
   assign f_valid       = (state == fetch_hold);
   assign f_instr       = slot;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= fetch_request;
         pc         <= RESET_PC;
         imem_valid <= 1'b0;
      end else begin
         case (state)
            fetch_request: begin
               if (imem_valid && imem_ready) begin
                  imem_valid <= 1'b0;
                  state      <= fetch_wait;
               end else begin
                  imem_valid <= 1'b1;  // First request after reset
               end
            end
            fetch_wait: begin
               if (imem_dp_valid) begin
                  state <= fetch_hold;
               end
            end
            fetch_hold: begin
               // Next request goes out as soon as decode has the word
               if (f_ready) begin
                  pc         <= pc + addr_t'(INSTR_BYTES);
                  imem_valid <= 1'b1;
                  state      <= fetch_request;
               end
            end
            default: begin
               state <= fetch_request;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (imem_dp_valid && imem_dp_ready) begin
         slot <= imem_dp_read_data;
      end
   end

endmodule

//--- source/cpu_pkg.sv
package cpu_pkg;

   typedef logic [31:0] addr_t;
   typedef logic [31:0] word_t;
   typedef logic [2:0]  reg_idx_t;

   typedef enum logic [3:0] {
      op_movi  = 4'd0,
      op_add   = 4'd1,
      op_sub   = 4'd2,
      op_and   = 4'd3,
      op_or    = 4'd4,
      op_xor   = 4'd5,
      op_store = 4'd6,
      op_halt  = 4'd7   // Also every undefined code
   } opcode_e;

   localparam int OPC_LSB     = 28;
   localparam int DST_LSB     = 25;
   localparam int SRC_LSB     = 22;
   localparam int IMM_W       = 16;
   localparam int INSTR_BYTES = 4;
   localparam int NUM_REGS    = 8;

   typedef struct packed {
      opcode_e  opcode;
      reg_idx_t dst;
      reg_idx_t src;
      word_t    imm;      // Zero extended
   } decoded_t;

   typedef struct packed {
      opcode_e  opcode;
      reg_idx_t dst;
      word_t    a;        // Value of dst
      word_t    b;        // Value of src
      word_t    imm;
   } operands_t;

   typedef struct packed {
      opcode_e  opcode;
      reg_idx_t dst;
      word_t    value;
      addr_t    address;  // Store target
   } result_t;

   function automatic logic writes_reg(opcode_e op);
      return (op != op_store) && (op != op_halt);
   endfunction

endpackage
